//--- sim.f
+incdir+logic
logic/fxp_pkg.sv
logic/net_pkg.sv
logic/param_store.sv
logic/fxp_mac.sv
logic/layer_sequencer.sv
logic/arrhythmia_top.sv
testbench/tb_arrhythmia.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the arrhythmia engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_arrhythmia \
    -Mdir "$OBJ" -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -qx "Done: no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- testbench/tb_arrhythmia.sv
/* testbench for the arrhythmia classifier engine
   random parameters and features against an integer reference model */

`include "nn_macros.svh"

module tb_arrhythmia
    import fxp_pkg::*;
    import net_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_TIMEOUT = 2000;
    localparam fxp_word_t POS_MAX = '{sign: 1'b0, mag: 15'h7fff};
    localparam fxp_word_t NEG_MAX = '{sign: 1'b1, mag: 15'h7fff};

    logic         clk;
    logic         reset;
    feature_vec_t features;
    logic         req;
    logic         ack;
    net_result_t  result;
    param_wr_t    param_wr;

    // host copy of everything written into the store
    fxp_word_t w_model [4][`NN_HID][`NN_MAX_FANIN];
    fxp_word_t b_model [4][`NN_HID];

    int value_errors;
    int timeout_errors;

    arrhythmia_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .features (features),
        .req      (req),
        .ack      (ack),
        .result   (result),
        .param_wr (param_wr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // layer shapes, order hid, mean, cls, logit
    function automatic int rows_of(input int layer);
        case (layer)
            0:       return `NN_HID;
            1:       return `NN_LAT;
            2:       return `NN_HID;
            default: return `NN_OUT;
        endcase
    endfunction

    function automatic int cols_of(input int layer);
        case (layer)
            0:       return `NN_IN;
            1:       return `NN_HID;
            2:       return `NN_LAT;
            default: return `NN_HID;
        endcase
    endfunction

    function automatic fxp_word_t make_word(input logic sign, input int mag);
        fxp_word_t w;
        w.mag = 15'(mag);
        w.sign = sign && (mag != 0);
        return w;
    endfunction

    // magnitude below 2.0
    function automatic fxp_word_t rand_small();
        return make_word(1'($urandom_range(1, 0)), int'($urandom_range(511, 0)));
    endfunction

    function automatic feature_vec_t rand_features();
        feature_vec_t f;
        for (int i = 0; i < `NN_IN; i++) begin
            f[i] = rand_small();
        end
        return f;
    endfunction

    // reference arithmetic on signed integers in units of 1/256
    function automatic longint word_value(input fxp_word_t w);
        return w.sign ? -longint'(w.mag) : longint'(w.mag);
    endfunction

    // clip to full scale, zero comes out positive
    function automatic fxp_word_t value_word(input longint v);
        longint m;
        m = (v < 0) ? -v : v;
        if (m > 32767) begin
            m = 32767;
        end
        return make_word(v < 0, int'(m));
    endfunction

    // magnitude product truncated, not rounded toward minus infinity
    function automatic fxp_word_t model_mul(input fxp_word_t a, input fxp_word_t b);
        longint m;
        m = (longint'(a.mag) * longint'(b.mag)) >> `NN_FRAC_BITS;
        return value_word((a.sign ^ b.sign) ? -m : m);
    endfunction

    function automatic fxp_word_t model_add(input fxp_word_t a, input fxp_word_t b);
        return value_word(word_value(a) + word_value(b));
    endfunction

    // bias first, then columns in ascending order
    task automatic model_layer(input int layer, input fxp_word_t act_in [`NN_HID],
                               output fxp_word_t act_out [`NN_HID]);
        fxp_word_t acc;
        for (int r = 0; r < `NN_HID; r++) begin
            act_out[r] = '0;
        end
        for (int r = 0; r < rows_of(layer); r++) begin
            acc = b_model[layer][r];
            for (int c = 0; c < cols_of(layer); c++) begin
                acc = model_add(acc, model_mul(act_in[c], w_model[layer][r][c]));
            end
            // rectifier on both hidden layers
            if ((layer == 0 || layer == 2) && acc.sign) begin
                acc = '0;
            end
            act_out[r] = acc;
        end
    endtask

    task automatic model_inference(input feature_vec_t f, output net_result_t exp);
        fxp_word_t a [`NN_HID];
        fxp_word_t b [`NN_HID];
        for (int i = 0; i < `NN_HID; i++) begin
            a[i] = (i < `NN_IN) ? f[i] : '0;
        end
        model_layer(0, a, b);
        model_layer(1, b, a);
        for (int i = 0; i < `NN_LAT; i++) begin
            exp.latent[i] = a[i];
        end
        model_layer(2, a, b);
        model_layer(3, b, a);
        for (int i = 0; i < `NN_OUT; i++) begin
            exp.logits[i] = a[i];
        end
    endtask

    task automatic check_latent(input string name, input latent_vec_t got,
                                input latent_vec_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_logits(input string name, input logit_vec_t got,
                                input logit_vec_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // zero must never carry a minus sign
    task automatic check_zero_sign();
        for (int i = 0; i < `NN_LAT; i++) begin
            if (result.latent[i].mag == '0) begin
                check_bit($sformatf("result.latent[%0d].sign", i), result.latent[i].sign, 1'b0);
            end
        end
        for (int i = 0; i < `NN_OUT; i++) begin
            if (result.logits[i].mag == '0) begin
                check_bit($sformatf("result.logits[%0d].sign", i), result.logits[i].sign, 1'b0);
            end
        end
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) begin
            timeout_errors++;
            $display("timeout: ack did not reach %b within %0d cycles", level, ACK_TIMEOUT);
        end
    endtask

    // idle write, mirrored into the model
    task automatic write_param(input int layer, input logic is_bias, input int row,
                               input int col, input fxp_word_t data);
        param_wr = '{valid: 1'b1, layer: layer_id_t'(layer), is_bias: is_bias,
                     row: nn_idx_t'(row), col: nn_idx_t'(col), data: data};
        if (is_bias) begin
            b_model[layer][row] = data;
        end else begin
            w_model[layer][row][col] = data;
        end
        @(negedge clk);
        param_wr.valid = 1'b0;
    endtask

    task automatic load_random_params();
        for (int l = 0; l < 4; l++) begin
            for (int r = 0; r < rows_of(l); r++) begin
                write_param(l, 1'b1, r, 0, rand_small());
                for (int c = 0; c < cols_of(l); c++) begin
                    write_param(l, 1'b0, r, c, rand_small());
                end
            end
        end
    endtask

    // large weights so every stage clips, logit 1 cancels to zero
    task automatic load_saturating();
        for (int l = 0; l < 4; l++) begin
            for (int r = 0; r < rows_of(l); r++) begin
                write_param(l, 1'b1, r, 0, '0);
                for (int c = 0; c < cols_of(l); c++) begin
                    case (l)
                        0: write_param(l, 1'b0, r, c, make_word(1'b0, 'h6400));
                        1: write_param(l, 1'b0, r, c, make_word(r == 1, 'h0100));
                        2: write_param(l, 1'b0, r, c, make_word(1'b0, (c == 0) ? 'h6400 : 0));
                        default: write_param(l, 1'b0, r, c,
                                             make_word((r == 1) && c[0], 'h6400));
                    endcase
                end
            end
        end
    endtask

    // writes while busy, left out of the model on purpose
    task automatic stray_writes(input int count);
        int l;
        for (int i = 0; i < count; i++) begin
            l = int'($urandom_range(3, 0));
            param_wr = '{valid: 1'b1, layer: layer_id_t'(l),
                         is_bias: 1'($urandom_range(1, 0)),
                         row: nn_idx_t'($urandom_range(rows_of(l) - 1, 0)),
                         col: nn_idx_t'($urandom_range(cols_of(l) - 1, 0)),
                         data: make_word(1'($urandom_range(1, 0)), 'h4000)};
            @(negedge clk);
        end
        param_wr.valid = 1'b0;
    endtask

    // one full four phase handshake, called on a falling edge
    task automatic run_inference(input feature_vec_t f, input int hold, input int strays);
        net_result_t exp;
        net_result_t held;
        features = f;
        req = 1'b1;
        if (strays > 0) begin
            // busy from the next rising edge on
            @(negedge clk);
            stray_writes(strays);
        end
        wait_ack(1'b1);
        model_inference(f, exp);
        check_latent("result.latent", result.latent, exp.latent);
        check_logits("result.logits", result.logits, exp.logits);
        check_zero_sign();
        held = result;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_bit("ack", ack, 1'b1);
            check_latent("result.latent", result.latent, held.latent);
            check_logits("result.logits", result.logits, held.logits);
        end
        req = 1'b0;
        // ack drops one cycle after req
        @(negedge clk);
        check_bit("ack", ack, 1'b0);
        // release state still counts as busy, idle one cycle later
        @(negedge clk);
    endtask

    initial begin
        feature_vec_t sat_f;
        latent_vec_t  lat_exp;
        logit_vec_t   log_exp;
        void'($urandom(32'hefab_0d08));
        value_errors = 0;
        timeout_errors = 0;
        reset = 1'b1;
        req = 1'b0;
        features = '0;
        param_wr = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // state right after reset
        check_bit("ack", ack, 1'b0);
        check_latent("result.latent", result.latent, '0);
        check_logits("result.logits", result.logits, '0);

        // fresh parameters every ten runs, stray writes every fourth
        for (int k = 0; k < 40; k++) begin
            if (k % 10 == 0) begin
                load_random_params();
            end
            run_inference(rand_features(), int'($urandom_range(6, 0)), (k % 4 == 2) ? 24 : 0);
        end

        load_saturating();
        for (int i = 0; i < `NN_IN; i++) begin
            sat_f[i] = make_word(1'b0, 'h6400);
        end
        run_inference(sat_f, 2, 0);
        lat_exp[0] = POS_MAX;
        lat_exp[1] = NEG_MAX;
        log_exp[0] = POS_MAX;
        log_exp[1] = '0;
        check_latent("saturated result.latent", result.latent, lat_exp);
        check_logits("saturated result.logits", result.logits, log_exp);

        $display("error counts: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- logic/arrhythmia_top.sv
/* arrhythmia classifier engine
   parameter store, layer sequencer and shared MAC datapath */

module arrhythmia_top
    import fxp_pkg::*;
    import net_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  feature_vec_t features,
    input  logic         req,
    output logic         ack,
    output net_result_t  result,
    input  param_wr_t    param_wr
);

    // sequencer to store
    logic      busy;
    param_rd_t rd;
    fxp_word_t weight;
    fxp_word_t bias;

    // sequencer to mac and back
    fxp_word_t operand;
    logic      first;
    logic      last;
    logic      relu_en;
    fxp_word_t neuron;
    logic      neuron_done;

    param_store store0 (
        .clk      (clk),
        .reset    (reset),
        .param_wr (param_wr),
        .busy     (busy),
        .rd       (rd),
        .weight   (weight),
        .bias     (bias)
    );

    layer_sequencer seq0 (
        .clk         (clk),
        .reset       (reset),
        .features    (features),
        .req         (req),
        .ack         (ack),
        .busy        (busy),
        .rd          (rd),
        .operand     (operand),
        .first       (first),
        .last        (last),
        .relu_en     (relu_en),
        .neuron      (neuron),
        .neuron_done (neuron_done),
        .result      (result)
    );

    fxp_mac mac0 (
        .clk         (clk),
        .reset       (reset),
        .operand     (operand),
        .weight      (weight),
        .bias        (bias),
        .first       (first),
        .last        (last),
        .relu_en     (relu_en),
        .neuron      (neuron),
        .neuron_done (neuron_done)
    );

endmodule

//--- logic/layer_sequencer.sv
/* req/ack control and layer/neuron loops of the inference
   feeds the shared MAC and keeps the activation buffers */

`include "nn_macros.svh"

module layer_sequencer
    import fxp_pkg::*;
    import net_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  feature_vec_t features,
    input  logic         req,
    output logic         ack,
    output logic         busy,
    output param_rd_t    rd,
    output fxp_word_t    operand,
    output logic         first,
    output logic         last,
    output logic         relu_en,
    input  fxp_word_t    neuron,
    input  logic         neuron_done,
    output net_result_t  result
);

    localparam int IN_AW  = $clog2(`NN_IN);
    localparam int HID_AW = $clog2(`NN_HID);
    localparam int LAT_AW = $clog2(`NN_LAT);
    localparam int OUT_AW = $clog2(`NN_OUT);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_RUN,
        ST_DRAIN,
        ST_HOLD,
        ST_RELEASE
    } state_t;

    state_t    state;
    layer_id_t cur_layer;
    nn_idx_t   row;
    nn_idx_t   col;
    nn_idx_t   wr_row;
    nn_idx_t   row_last;
    nn_idx_t   col_last;
    logic      issue;
    fxp_word_t op_sel;

    // activation buffers
    feature_vec_t feat_q;
    fxp_word_t    hid_buf [`NN_HID];
    // latent field doubles as the layer three input buffer
    net_result_t  res_q;

    assign row_last = layer_rows(cur_layer) - 1'b1;
    assign col_last = layer_cols(cur_layer) - 1'b1;
    assign issue    = state == ST_RUN;

    // store address goes out now, data comes back next cycle
    assign rd      = '{layer: cur_layer, row: row, col: col};
    assign ack     = state == ST_HOLD;
    assign busy    = state != ST_IDLE;
    assign result  = res_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            cur_layer <= LAYER_HID;
            row       <= '0;
            col       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_CAPTURE;
                    end
                end
                ST_CAPTURE: begin
                    cur_layer <= LAYER_HID;
                    row       <= '0;
                    col       <= '0;
                    state     <= ST_RUN;
                end
                // one term per cycle, column inner loop
                ST_RUN: begin
                    if (col == col_last) begin
                        col <= '0;
                        if (row == row_last) begin
                            row   <= '0;
                            state <= ST_DRAIN;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                // next layer reads this one, so wait for its last neuron
                ST_DRAIN: begin
                    if (neuron_done && (wr_row == row_last)) begin
                        if (cur_layer == LAYER_LOGIT) begin
                            state <= ST_HOLD;
                        end else begin
                            cur_layer <= layer_id_t'(cur_layer + 2'd1);
                            state     <= ST_RUN;
                        end
                    end
                end
                ST_HOLD: begin
                    if (!req) begin
                        state <= ST_RELEASE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // write pointer for returned neurons, wraps at the end of a layer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_row <= '0;
        end else if (neuron_done) begin
            wr_row <= (wr_row == row_last) ? '0 : wr_row + 1'b1;
        end
    end

    // operand source follows the layer
    always_comb begin
        case (cur_layer)
            LAYER_HID:  op_sel = feat_q[col[IN_AW-1:0]];
            LAYER_MEAN: op_sel = hid_buf[col[HID_AW-1:0]];
            LAYER_CLS:  op_sel = res_q.latent[col[LAT_AW-1:0]];
            default:    op_sel = hid_buf[col[HID_AW-1:0]];
        endcase
    end

    // delayed one stage to meet the store data
    always_ff @(posedge clk) begin
        operand <= op_sel;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            first   <= 1'b0;
            last    <= 1'b0;
            relu_en <= 1'b0;
        end else begin
            first   <= issue && (col == '0);
            last    <= issue && (col == col_last);
            // rectifier on both hidden layers
            relu_en <= issue && ((cur_layer == LAYER_HID) || (cur_layer == LAYER_CLS));
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_CAPTURE) begin
            feat_q <= features;
        end
        if (neuron_done && ((cur_layer == LAYER_HID) || (cur_layer == LAYER_CLS))) begin
            hid_buf[wr_row[HID_AW-1:0]] <= neuron;
        end
    end

    // latent mean and logits, held through the ack phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_q <= '0;
        end else if (neuron_done) begin
            if (cur_layer == LAYER_MEAN) begin
                res_q.latent[wr_row[LAT_AW-1:0]] <= neuron;
            end else if (cur_layer == LAYER_LOGIT) begin
                res_q.logits[wr_row[OUT_AW-1:0]] <= neuron;
            end
        end
    end

endmodule

//--- logic/fxp_mac.sv
/* two stage multiply-accumulate for one neuron at a time
   bias preload on the first term, optional rectifier on the last */

module fxp_mac
    import fxp_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  fxp_word_t operand,
    input  fxp_word_t weight,
    input  fxp_word_t bias,
    input  logic      first,
    input  logic      last,
    input  logic      relu_en,
    output fxp_word_t neuron,
    output logic      neuron_done
);

    // stage one registers
    fxp_word_t prod_q;
    fxp_word_t bias_q;
    logic      first_q;
    logic      last_q;
    logic      relu_q;

    // stage two
    fxp_word_t acc_q;
    fxp_word_t acc_next;

    // product and bias ride together
    always_ff @(posedge clk) begin
        prod_q <= fxp_mul(operand, weight);
        bias_q <= bias;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            first_q <= 1'b0;
            last_q  <= 1'b0;
            relu_q  <= 1'b0;
        end else begin
            first_q <= first;
            last_q  <= last;
            relu_q  <= relu_en;
        end
    end

    // first term starts from the bias, later terms from the running sum
    assign acc_next = first_q ? fxp_add(bias_q, prod_q) : fxp_add(acc_q, prod_q);

    always_ff @(posedge clk) begin
        acc_q <= acc_next;
        // finished neuron, rectified for hidden layers
        if (last_q) begin
            neuron <= relu_q ? fxp_relu(acc_next) : acc_next;
        end
    end

    // done lines up with the neuron register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            neuron_done <= 1'b0;
        end else begin
            neuron_done <= last_q;
        end
    end

endmodule

//--- logic/param_store.sv
/* weight and bias memories for the four layers
   host write port, registered read port for the sequencer */

`include "nn_macros.svh"

module param_store
    import fxp_pkg::*;
    import net_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  param_wr_t param_wr,
    input  logic      busy,
    input  param_rd_t rd,
    output fxp_word_t weight,
    output fxp_word_t bias
);

    localparam int ROW_AW = $clog2(`NN_HID);
    localparam int COL_AW = $clog2(`NN_MAX_FANIN);

    // one plane per layer, sized for the widest layer
    fxp_word_t w_mem [4][`NN_HID][`NN_MAX_FANIN];
    fxp_word_t b_mem [4][`NN_HID];

    logic wr_in_dims;
    logic wr_en;
    logic rd_w_ok;
    logic rd_b_ok;

    // bias writes ignore col
    assign wr_in_dims = (param_wr.row < layer_rows(param_wr.layer)) &&
                        (param_wr.is_bias || (param_wr.col < layer_cols(param_wr.layer)));
    // host writes only land while the engine is idle
    assign wr_en = param_wr.valid && !busy && wr_in_dims;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (param_wr.is_bias) begin
                b_mem[param_wr.layer][param_wr.row[ROW_AW-1:0]] <= param_wr.data;
            end else begin
                w_mem[param_wr.layer][param_wr.row[ROW_AW-1:0]][param_wr.col[COL_AW-1:0]]
                    <= param_wr.data;
            end
        end
    end

    // out of range reads give zero
    assign rd_b_ok = rd.row < layer_rows(rd.layer);
    assign rd_w_ok = rd_b_ok && (rd.col < layer_cols(rd.layer));

    // one cycle read latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            weight <= '0;
            bias   <= '0;
        end else begin
            weight <= rd_w_ok ? w_mem[rd.layer][rd.row[ROW_AW-1:0]][rd.col[COL_AW-1:0]] : '0;
            bias   <= rd_b_ok ? b_mem[rd.layer][rd.row[ROW_AW-1:0]] : '0;
        end
    end

endmodule

//--- logic/net_pkg.sv
/* network structure types
   layer ids, parameter access structs, feature and result vectors */

`include "nn_macros.svh"

package net_pkg;

    import fxp_pkg::*;

    // processing order of the four dense layers
    typedef enum logic [1:0] {
        LAYER_HID,
        LAYER_MEAN,
        LAYER_CLS,
        LAYER_LOGIT
    } layer_id_t;

    typedef logic [`NN_IDX_BITS-1:0] nn_idx_t;

    // host write, row is the neuron and col the input
    typedef struct packed {
        logic      valid;
        layer_id_t layer;
        logic      is_bias;
        nn_idx_t   row;
        nn_idx_t   col;
        fxp_word_t data;
    } param_wr_t;

    typedef struct packed {
        layer_id_t layer;
        nn_idx_t   row;
        nn_idx_t   col;
    } param_rd_t;

    typedef fxp_word_t [`NN_IN-1:0] feature_vec_t;
    typedef fxp_word_t [`NN_LAT-1:0] latent_vec_t;
    typedef fxp_word_t [`NN_OUT-1:0] logit_vec_t;

    typedef struct packed {
        latent_vec_t latent;
        logit_vec_t  logits;
    } net_result_t;

    // neurons per layer
    function automatic nn_idx_t layer_rows(input layer_id_t layer);
        case (layer)
            LAYER_HID:  return nn_idx_t'(`NN_HID);
            LAYER_MEAN: return nn_idx_t'(`NN_LAT);
            LAYER_CLS:  return nn_idx_t'(`NN_HID);
            default:    return nn_idx_t'(`NN_OUT);
        endcase
    endfunction

    // inputs per neuron
    function automatic nn_idx_t layer_cols(input layer_id_t layer);
        case (layer)
            LAYER_HID:  return nn_idx_t'(`NN_IN);
            LAYER_MEAN: return nn_idx_t'(`NN_HID);
            LAYER_CLS:  return nn_idx_t'(`NN_LAT);
            default:    return nn_idx_t'(`NN_HID);
        endcase
    endfunction

endpackage

//--- logic/fxp_pkg.sv
/* sign-magnitude fixed point format
   word type plus saturating multiply, add and rectifier */

`include "nn_macros.svh"

package fxp_pkg;

    localparam int FXP_MAG_BITS = `NN_WORD_BITS - 1;
    localparam logic [FXP_MAG_BITS-1:0] FXP_MAG_MAX = '1;

    // sign on top, magnitude below
    typedef struct packed {
        logic                    sign;
        logic [FXP_MAG_BITS-1:0] mag;
    } fxp_word_t;

    // product, truncated then clipped to full scale
    function automatic fxp_word_t fxp_mul(input fxp_word_t a, input fxp_word_t b);
        logic [2*FXP_MAG_BITS-1:0] full;
        logic [2*FXP_MAG_BITS-1:0] scaled;
        fxp_word_t r;
        full = {{FXP_MAG_BITS{1'b0}}, a.mag} * {{FXP_MAG_BITS{1'b0}}, b.mag};
        scaled = full >> `NN_FRAC_BITS;
        if (|scaled[2*FXP_MAG_BITS-1:FXP_MAG_BITS]) begin
            r.mag = FXP_MAG_MAX;
        end else begin
            r.mag = scaled[FXP_MAG_BITS-1:0];
        end
        // no negative zero
        r.sign = (a.sign ^ b.sign) & (r.mag != '0);
        return r;
    endfunction

    function automatic fxp_word_t fxp_add(input fxp_word_t a, input fxp_word_t b);
        logic [FXP_MAG_BITS:0] sum;
        fxp_word_t r;
        sum = {1'b0, a.mag} + {1'b0, b.mag};
        if (a.sign == b.sign) begin
            // same sign, carry out means overflow
            r.mag = sum[FXP_MAG_BITS] ? FXP_MAG_MAX : sum[FXP_MAG_BITS-1:0];
            r.sign = a.sign;
        end else if (a.mag >= b.mag) begin
            r.mag = a.mag - b.mag;
            r.sign = a.sign;
        end else begin
            r.mag = b.mag - a.mag;
            r.sign = b.sign;
        end
        if (r.mag == '0) begin
            r.sign = 1'b0;
        end
        return r;
    endfunction

    // negative words clamp to zero
    function automatic fxp_word_t fxp_relu(input fxp_word_t a);
        return a.sign ? '0 : a;
    endfunction

endpackage

//--- logic/nn_macros.svh
/* network size and number format constants
   shared by the packages, the parameter store and the testbench */

`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// word layout, sign-magnitude with 8 fraction bits
`define NN_WORD_BITS 16
`define NN_FRAC_BITS 8

// layer widths
`define NN_IN 10
`define NN_HID 16
`define NN_LAT 2
`define NN_OUT 2

// widest fan-in over all four layers
`define NN_MAX_FANIN 16
// row and column index width, one spare bit for range checks
`define NN_IDX_BITS 5

`endif
